// File: Makefile
# Verilator build for the execute datapath and its testbench

VERILATOR ?= verilator
TOP       ?= dataPathTb
RTL_TOP   ?= dataPath
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulation is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
verilog/cpuPkg.sv
verilog/registerFile.sv
verilog/instrDecoder.sv
verilog/shifter.sv
verilog/executeUnit.sv
verilog/dataPath.sv
verification/dataPathTb.sv

// File: verification/dataPathTb.sv
`default_nettype none
`timescale 1ns/1ps

module dataPathTb;

	localparam int DATA_BITS    = 16;
	localparam int CLK_HALF     = 10;
	localparam int RESET_CYCLES = 4;
	localparam int RANDOM_COUNT = 500;
	localparam int DIRECTED_MAX = 400; // directed tests stay well below this
	// a random instr is followed by at most one idle cycle
	localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED_MAX + 2 * RANDOM_COUNT;
	localparam int TIMEOUT_NS   = TOTAL_CYCLES * 2 * CLK_HALF + 1000;
	// +1 +4 +15 -1 -5 -15 -16 0
	localparam logic [4:0] SHIFT_AMTS [8] = '{5'h01, 5'h04, 5'h0F, 5'h1F,
		5'h1B, 5'h11, 5'h10, 5'h00};

	logic                 clk;
	logic                 rstN;
	logic [15:0]          instr;
	logic                 instrValid;
	logic [DATA_BITS-1:0] result;
	logic                 writeEn;
	logic                 illegal;
	logic [4:0]           psr;

	logic [15:0] modelRegs [16]; // reference register file
	logic [4:0]  modelPsr;
	logic [31:0] rngState;

	dataPath #(.DATA_BITS(DATA_BITS)) DUT (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.result     (result),
		.writeEn    (writeEn),
		.illegal    (illegal),
		.psr        (psr)
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] dst,
		input logic [3:0] ext, input logic [3:0] src);
		return {op, dst, ext, src};
	endfunction

	function automatic logic [15:0] immForm(input logic [3:0] op, input logic [3:0] dst,
		input logic [7:0] imm);
		return {op, dst, imm};
	endfunction

	// k is the source position of output bit i
	function automatic logic [15:0] shiftRef(input logic [15:0] v, input logic [4:0] amt,
		input logic arith);
		logic [15:0] r;
		int          n;
		int          k;
		n = amt[4] ? int'(amt) - 32 : int'(amt); // 5 bit two's complement
		for (int i = 0; i < 16; i++) begin
			k = i - n;
			if (k < 0) r[i] = 1'b0;               // left shift fills zeros
			else if (k > 15) r[i] = arith & v[15]; // right shift fill
			else r[i] = v[4'(k)];
		end
		return r;
	endfunction

	function automatic logic [4:0] addFlags(input logic [15:0] a, input logic [15:0] b,
		input logic [4:0] p);
		logic [4:0] q;
		int         s;
		q = p;
		s = int'($signed(a)) + int'($signed(b));
		q[cpuPkg::PSR_C] = (int'(a) + int'(b)) > 65535;
		q[cpuPkg::PSR_F] = (s > 32767) || (s < -32768);
		return q;
	endfunction

	function automatic logic [4:0] subFlags(input logic [15:0] a, input logic [15:0] b,
		input logic [4:0] p);
		logic [4:0] q;
		int         s;
		q = p;
		s = int'($signed(a)) - int'($signed(b));
		q[cpuPkg::PSR_C] = a < b; // borrow
		q[cpuPkg::PSR_F] = (s > 32767) || (s < -32768);
		return q;
	endfunction

	function automatic logic [4:0] cmpFlags(input logic [15:0] a, input logic [15:0] b,
		input logic [4:0] p);
		logic [4:0] q;
		q = p;
		q[cpuPkg::PSR_Z] = a == b;
		q[cpuPkg::PSR_N] = $signed(a) < $signed(b);
		q[cpuPkg::PSR_L] = a < b;
		return q;
	endfunction

	// expected outputs for one instr against the current model state
	task automatic predict(input logic [15:0] ins, input logic v, output logic [15:0] res,
		output logic we, output logic ill, output logic [4:0] psrNext);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sx;
		logic [15:0] zx;
		logic        legal;
		logic        isCmp;
		a       = modelRegs[ins[11:8]]; // dst
		b       = modelRegs[ins[3:0]];  // src
		sx      = {{8{ins[7]}}, ins[7:0]};
		zx      = {8'h00, ins[7:0]};
		legal   = 1'b1;
		isCmp   = 1'b0;
		res     = '0;
		psrNext = modelPsr;
		case (ins[15:12])
			cpuPkg::REGOP: begin
				case (ins[7:4])
					cpuPkg::ADD: begin
						res     = a + b;
						psrNext = addFlags(a, b, modelPsr);
					end
					cpuPkg::SUB: begin
						res     = a - b;
						psrNext = subFlags(a, b, modelPsr);
					end
					cpuPkg::AND: res = a & b;
					cpuPkg::OR:  res = a | b;
					cpuPkg::XOR: res = a ^ b;
					cpuPkg::MOV: res = b;
					cpuPkg::CMP: begin
						isCmp   = 1'b1;
						psrNext = cmpFlags(a, b, modelPsr);
					end
					default: legal = 1'b0;
				endcase
			end
			cpuPkg::ADDI: begin
				res     = a + sx;
				psrNext = addFlags(a, sx, modelPsr);
			end
			cpuPkg::SUBI: begin
				res     = a - sx;
				psrNext = subFlags(a, sx, modelPsr);
			end
			cpuPkg::ANDI: res = a & zx;
			cpuPkg::ORI:  res = a | zx;
			cpuPkg::XORI: res = a ^ zx;
			cpuPkg::MOVI: res = sx;
			cpuPkg::CMPI: begin
				isCmp   = 1'b1;
				psrNext = cmpFlags(a, sx, modelPsr);
			end
			cpuPkg::LUI:  res = {ins[7:0], 8'h00};
			cpuPkg::LSH:  res = shiftRef(a, b[4:0], ins[7:4] == 4'd1);
			cpuPkg::LSHI: res = shiftRef(a, ins[4:0], 1'b0); // always logical
			default: legal = 1'b0;
		endcase
		if (!(v && legal)) psrNext = modelPsr; // no flag change
		we  = v && legal && !isCmp;
		ill = v && !legal;
	endtask

	task automatic expectEq(input string name, input logic [15:0] ins,
		input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h (instr %h)", name, got, exp, ins);
			$display("Test FAILED");
			$fatal(1, "output check failed");
		end
	endtask

	// drive on the rising edge and check at the falling edge
	task automatic issue(input logic [15:0] ins, input logic v);
		logic [15:0] expRes;
		logic        expWe;
		logic        expIll;
		logic [4:0]  expPsrNext;
		@(posedge clk);
		instr      <= ins;
		instrValid <= v;
		@(negedge clk);
		predict(ins, v, expRes, expWe, expIll, expPsrNext);
		expectEq("writeEn", ins, 16'(writeEn), 16'(expWe));
		expectEq("illegal", ins, 16'(illegal), 16'(expIll));
		expectEq("psr", ins, 16'(psr), 16'(modelPsr)); // flags from earlier edges
		if (expWe) expectEq("result", ins, result, expRes);
		if (expWe) modelRegs[ins[11:8]] = expRes; // dut writes at the next edge
		modelPsr = expPsrNext;
	endtask

	task automatic idle();
		issue(16'(nextRand()), 1'b0); // junk word with valid low
	endtask

	task automatic loadReg(input logic [3:0] r, input logic [15:0] value);
		issue(immForm(cpuPkg::LUI, r, value[15:8]), 1'b1);
		issue(immForm(cpuPkg::ORI, r, value[7:0]), 1'b1);
	endtask

	// MOV rN,rN shows every register on result
	task automatic sweepRegs();
		for (int r = 0; r < 16; r++) begin
			issue(encode(cpuPkg::REGOP, 4'(r), cpuPkg::MOV, 4'(r)), 1'b1);
		end
	endtask

	function automatic logic [15:0] randomLegal();
		logic [15:0] w;
		w        = 16'(nextRand());
		w[15:12] = 4'(nextRand() % 32'd11);
		if (w[15:12] == cpuPkg::REGOP) w[7:4] = 4'(nextRand() % 32'd7);
		return w;
	endfunction

	initial begin
		clk        = 1'b0;
		rstN       = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		rngState   = 32'd24463;
		modelPsr   = '0;
		for (int i = 0; i < 16; i++) modelRegs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;

		// reset state
		issue(encode(cpuPkg::REGOP, 4'd3, cpuPkg::MOV, 4'd7), 1'b0);
		idle();
		sweepRegs();

		// each immediate read back the very next cycle
		issue(immForm(cpuPkg::MOVI, 4'd1, 8'h85), 1'b1);   // sign extends
		issue(encode(cpuPkg::REGOP, 4'd2, cpuPkg::MOV, 4'd1), 1'b1);
		issue(immForm(cpuPkg::MOVI, 4'd3, 8'h7F), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd7, cpuPkg::MOV, 4'd3), 1'b1);
		issue(immForm(cpuPkg::LUI, 4'd4, 8'hA5), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd5, cpuPkg::MOV, 4'd4), 1'b1);
		issue(immForm(cpuPkg::ADDI, 4'd4, 8'h80), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd5, cpuPkg::MOV, 4'd4), 1'b1);
		issue(immForm(cpuPkg::ANDI, 4'd1, 8'hF0), 1'b1);   // zero extends
		issue(encode(cpuPkg::REGOP, 4'd2, cpuPkg::MOV, 4'd1), 1'b1);
		issue(immForm(cpuPkg::ORI, 4'd3, 8'h80), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd7, cpuPkg::MOV, 4'd3), 1'b1);
		issue(immForm(cpuPkg::XORI, 4'd4, 8'hFF), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd6, cpuPkg::MOV, 4'd4), 1'b1);

		// carry, borrow and overflow edges
		loadReg(4'd1, 16'hFFFF);
		loadReg(4'd2, 16'h0001);
		issue(encode(cpuPkg::REGOP, 4'd1, cpuPkg::ADD, 4'd2), 1'b1); // carry out
		loadReg(4'd3, 16'h7FFF);
		issue(encode(cpuPkg::REGOP, 4'd3, cpuPkg::ADD, 4'd2), 1'b1); // signed ovf
		loadReg(4'd4, 16'h8000);
		issue(encode(cpuPkg::REGOP, 4'd4, cpuPkg::SUB, 4'd2), 1'b1);
		loadReg(4'd5, 16'h0000);
		issue(encode(cpuPkg::REGOP, 4'd5, cpuPkg::SUB, 4'd2), 1'b1); // borrow
		loadReg(4'd6, 16'h7FFF);
		issue(immForm(cpuPkg::ADDI, 4'd6, 8'h01), 1'b1);
		loadReg(4'd7, 16'h8000);
		issue(immForm(cpuPkg::SUBI, 4'd7, 8'h01), 1'b1);
		issue(immForm(cpuPkg::ADDI, 4'd2, 8'hFF), 1'b1);             // 1 + -1
		loadReg(4'd9, 16'h8000);
		loadReg(4'd10, 16'h0001);
		issue(encode(cpuPkg::REGOP, 4'd9, cpuPkg::CMP, 4'd10), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd10, cpuPkg::CMP, 4'd9), 1'b1);
		issue(encode(cpuPkg::REGOP, 4'd10, cpuPkg::CMP, 4'd10), 1'b1);
		issue(immForm(cpuPkg::CMPI, 4'd9, 8'h80), 1'b1);
		issue(immForm(cpuPkg::CMPI, 4'd10, 8'h01), 1'b1);
		sweepRegs(); // catches a stray compare write

		// shifts with junk above bit 4 of the amount
		for (int i = 0; i < 8; i++) begin
			loadReg(4'd1, 16'h9234);
			issue(immForm(cpuPkg::LSHI, 4'd1, {3'b101, SHIFT_AMTS[i]}), 1'b1);
			loadReg(4'd2, {11'h5A5, SHIFT_AMTS[i]});
			for (int e = 0; e < 2; e++) begin
				loadReg(4'd1, 16'h9234);
				issue(encode(cpuPkg::LSH, 4'd1, 4'(e), 4'd2), 1'b1); // e 1 is arith
			end
		end

		// undefined codes
		for (int op = 11; op < 16; op++) begin
			issue(immForm(4'(op), 4'(op), 8'(nextRand())), 1'b1);
		end
		for (int e = 7; e < 16; e++) begin
			issue(encode(cpuPkg::REGOP, 4'd1, 4'(e), 4'd2), 1'b1);
		end
		sweepRegs();

		// random back to back with some idle gaps
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			issue(randomLegal(), 1'b1);
			if ((nextRand() & 32'h3) == 32'h0) idle();
		end
		idle();
		sweepRegs();

		$display("Test OK");
		$finish;
	end

	// watchdog
	initial begin
		#TIMEOUT_NS;
		$display("run timed out after %0d ns without finishing", TIMEOUT_NS);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// major opcode, instr[15:12]
	typedef enum logic [3:0] {
		REGOP = 4'd0,  // register form, op in ext field
		ADDI  = 4'd1,
		SUBI  = 4'd2,
		ANDI  = 4'd3,
		ORI   = 4'd4,
		XORI  = 4'd5,
		MOVI  = 4'd6,
		CMPI  = 4'd7,
		LUI   = 4'd8,  // imm into upper byte
		LSH   = 4'd9,  // amount from src reg
		LSHI  = 4'd10  // amount from imm[4:0]
	} opcodeT;         // 11..15 unused, decoded as illegal

	// REGOP extension, instr[7:4]
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		MOV = 4'd5,
		CMP = 4'd6
	} regExtT;

	// what the execute unit actually does
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MOV,
		ALU_CMP,
		ALU_SHIFT
	} aluOpT;

	// instruction word layout
	localparam int INSTR_BITS = 16;
	localparam int OP_HI      = 15;
	localparam int OP_LO      = 12;
	localparam int DST_HI     = 11;
	localparam int DST_LO     = 8;
	localparam int EXT_HI     = 7;
	localparam int EXT_LO     = 4;
	localparam int SRC_HI     = 3;
	localparam int SRC_LO     = 0;
	localparam int IMM_BITS   = 8;  // imm is instr[7:0]

	localparam logic [3:0] EXT_ARITH = 4'd1; // LSH ext value for arithmetic shift

	// psr bit positions
	localparam int PSR_C    = 0; // carry / borrow
	localparam int PSR_F    = 1; // signed overflow
	localparam int PSR_L    = 2; // unsigned less
	localparam int PSR_Z    = 3; // equal
	localparam int PSR_N    = 4; // signed less
	localparam int PSR_BITS = 5;

	// register file geometry, fixed by the 4-bit reg fields
	localparam int REG_COUNT     = 16;
	localparam int REG_ADDR_BITS = 4;

endpackage

`default_nettype wire

// File: verilog/dataPath.sv
`default_nettype none
`timescale 1ns/1ps

module dataPath #(
	parameter int DATA_BITS = 16
) (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic [cpuPkg::INSTR_BITS-1:0] instr,
	input  logic                          instrValid,
	output logic [DATA_BITS-1:0]          result,   // value to write this cycle
	output logic                          writeEn,
	output logic                          illegal,
	output logic [cpuPkg::PSR_BITS-1:0]   psr
);

	logic [cpuPkg::REG_ADDR_BITS-1:0] rSrc;
	logic [cpuPkg::REG_ADDR_BITS-1:0] rDst;
	cpuPkg::aluOpT                    aluOp;
	logic                             shiftArith;
	logic                             useImm;
	logic [cpuPkg::INSTR_BITS-1:0]    immValue;
	logic                             setsFlags;
	logic [DATA_BITS-1:0]             srcData;
	logic [DATA_BITS-1:0]             dstData;
	logic [DATA_BITS-1:0]             opB;
	logic [DATA_BITS-1:0]             shifted;

	instrDecoder uDecoder (
		.instr      (instr),
		.instrValid (instrValid),
		.rSrc       (rSrc),
		.rDst       (rDst),
		.aluOp      (aluOp),
		.shiftArith (shiftArith),
		.useImm     (useImm),
		.immValue   (immValue),
		.writeEn    (writeEn),
		.setsFlags  (setsFlags),
		.illegal    (illegal)
	);

	registerFile #(.DATA_BITS(DATA_BITS)) uRegFile (
		.clk       (clk),
		.rstN      (rstN),
		.writeEn   (writeEn),
		.writeData (result),   // write back straight from the alu
		.srcAddr   (rSrc),
		.dstAddr   (rDst),
		.readData1 (srcData),
		.readData2 (dstData)
	);

	// second operand, also feeds the shift amount
	assign opB = useImm ? DATA_BITS'(immValue) : srcData;

	shifter #(.DATA_BITS(DATA_BITS)) uShifter (
		.value   (dstData),
		.amount  (opB[4:0]),   // signed amount from imm or src
		.arith   (shiftArith),
		.shifted (shifted)
	);

	executeUnit #(.DATA_BITS(DATA_BITS)) uExec (
		.clk       (clk),
		.rstN      (rstN),
		.aluOp     (aluOp),
		.opA       (dstData),
		.opB       (opB),
		.shifted   (shifted),
		.setsFlags (setsFlags),
		.result    (result),
		.psr       (psr)
	);

endmodule

`default_nettype wire

// File: verilog/executeUnit.sv
`default_nettype none
`timescale 1ns/1ps

// alu, result mux and psr
module executeUnit #(
	parameter int DATA_BITS = 16
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  cpuPkg::aluOpT               aluOp,
	input  logic [DATA_BITS-1:0]        opA,       // dst reg
	input  logic [DATA_BITS-1:0]        opB,       // src reg or imm
	input  logic [DATA_BITS-1:0]        shifted,   // shifter output
	input  logic                        setsFlags, // valid legal flag op
	output logic [DATA_BITS-1:0]        result,
	output logic [cpuPkg::PSR_BITS-1:0] psr
);

	localparam int MSB = DATA_BITS - 1;

	logic [DATA_BITS:0]          sum;   // top bit is carry out
	logic [DATA_BITS:0]          diff;  // top bit is borrow
	logic                        addOvf;
	logic                        subOvf;
	logic [cpuPkg::PSR_BITS-1:0] psrNext;

	assign sum  = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};

	// same signs in, different sign out
	assign addOvf = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
	// opposite signs in, result sign differs from opA
	assign subOvf = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);

	always_comb begin
		case (aluOp)
			cpuPkg::ALU_ADD:   result = sum[DATA_BITS-1:0];
			cpuPkg::ALU_SUB:   result = diff[DATA_BITS-1:0];
			cpuPkg::ALU_AND:   result = opA & opB;
			cpuPkg::ALU_OR:    result = opA | opB;
			cpuPkg::ALU_XOR:   result = opA ^ opB;
			cpuPkg::ALU_MOV:   result = opB;
			cpuPkg::ALU_CMP:   result = diff[DATA_BITS-1:0]; // never written back
			cpuPkg::ALU_SHIFT: result = shifted;
			default:           result = opB;
		endcase
	end

	// flags not touched by the op keep their value
	always_comb begin
		psrNext = psr;
		case (aluOp)
			cpuPkg::ALU_ADD: begin
				psrNext[cpuPkg::PSR_C] = sum[DATA_BITS];
				psrNext[cpuPkg::PSR_F] = addOvf;
			end
			cpuPkg::ALU_SUB: begin
				psrNext[cpuPkg::PSR_C] = diff[DATA_BITS];
				psrNext[cpuPkg::PSR_F] = subOvf;
			end
			cpuPkg::ALU_CMP: begin
				psrNext[cpuPkg::PSR_Z] = (opA == opB);
				psrNext[cpuPkg::PSR_N] = ($signed(opA) < $signed(opB));
				psrNext[cpuPkg::PSR_L] = (opA < opB);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			psr <= '0;
		end else if (setsFlags) begin
			psr <= psrNext; // same edge as the reg write
		end
	end

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module instrDecoder (
	input  logic [cpuPkg::INSTR_BITS-1:0]    instr,
	input  logic                             instrValid,
	output logic [cpuPkg::REG_ADDR_BITS-1:0] rSrc,
	output logic [cpuPkg::REG_ADDR_BITS-1:0] rDst,
	output cpuPkg::aluOpT                    aluOp,
	output logic                             shiftArith, // sign fill on right shift
	output logic                             useImm,     // opB from immValue
	output logic [cpuPkg::INSTR_BITS-1:0]    immValue,   // already extended
	output logic                             writeEn,
	output logic                             setsFlags,
	output logic                             illegal
);

	localparam int PAD_BITS = cpuPkg::INSTR_BITS - cpuPkg::IMM_BITS;

	cpuPkg::opcodeT                opcode;
	cpuPkg::regExtT                ext;
	logic [cpuPkg::IMM_BITS-1:0]   imm8;
	logic [cpuPkg::INSTR_BITS-1:0] immSext;
	logic [cpuPkg::INSTR_BITS-1:0] immZext;
	logic [cpuPkg::INSTR_BITS-1:0] immUpper;
	logic                          legal;  // code is defined
	logic                          isCmp;  // compare, no write back
	logic                          flagOp; // updates psr

	// field split
	assign opcode = cpuPkg::opcodeT'(instr[cpuPkg::OP_HI:cpuPkg::OP_LO]);
	assign ext    = cpuPkg::regExtT'(instr[cpuPkg::EXT_HI:cpuPkg::EXT_LO]);
	assign rDst   = instr[cpuPkg::DST_HI:cpuPkg::DST_LO];
	assign rSrc   = instr[cpuPkg::SRC_HI:cpuPkg::SRC_LO];
	assign imm8   = instr[cpuPkg::IMM_BITS-1:0];

	// the three immediate flavours
	assign immSext  = {{PAD_BITS{imm8[cpuPkg::IMM_BITS-1]}}, imm8};
	assign immZext  = {{PAD_BITS{1'b0}}, imm8};
	assign immUpper = {imm8, {PAD_BITS{1'b0}}}; // LUI, low byte zero

	always_comb begin
		aluOp      = cpuPkg::ALU_MOV;
		useImm     = 1'b1;
		immValue   = immSext;  // most imm ops sign extend
		shiftArith = 1'b0;
		legal      = 1'b1;
		isCmp      = 1'b0;
		flagOp     = 1'b0;
		case (opcode)
			cpuPkg::REGOP: begin
				useImm = 1'b0; // opB is src reg
				case (ext)
					cpuPkg::ADD: begin
						aluOp  = cpuPkg::ALU_ADD;
						flagOp = 1'b1;
					end
					cpuPkg::SUB: begin
						aluOp  = cpuPkg::ALU_SUB;
						flagOp = 1'b1;
					end
					cpuPkg::AND: aluOp = cpuPkg::ALU_AND;
					cpuPkg::OR:  aluOp = cpuPkg::ALU_OR;
					cpuPkg::XOR: aluOp = cpuPkg::ALU_XOR;
					cpuPkg::MOV: aluOp = cpuPkg::ALU_MOV;
					cpuPkg::CMP: begin
						aluOp  = cpuPkg::ALU_CMP;
						isCmp  = 1'b1;
						flagOp = 1'b1;
					end
					default: legal = 1'b0; // undefined ext
				endcase
			end
			cpuPkg::ADDI: begin
				aluOp  = cpuPkg::ALU_ADD;
				flagOp = 1'b1;
			end
			cpuPkg::SUBI: begin
				aluOp  = cpuPkg::ALU_SUB;
				flagOp = 1'b1;
			end
			cpuPkg::ANDI: begin
				aluOp    = cpuPkg::ALU_AND;
				immValue = immZext; // logic ops zero extend
			end
			cpuPkg::ORI: begin
				aluOp    = cpuPkg::ALU_OR;
				immValue = immZext;
			end
			cpuPkg::XORI: begin
				aluOp    = cpuPkg::ALU_XOR;
				immValue = immZext;
			end
			cpuPkg::MOVI: aluOp = cpuPkg::ALU_MOV;
			cpuPkg::CMPI: begin
				aluOp  = cpuPkg::ALU_CMP;
				isCmp  = 1'b1;
				flagOp = 1'b1;
			end
			cpuPkg::LUI: begin
				aluOp    = cpuPkg::ALU_MOV;
				immValue = immUpper;
			end
			cpuPkg::LSH: begin
				aluOp      = cpuPkg::ALU_SHIFT;
				useImm     = 1'b0; // amount from src reg
				shiftArith = (instr[cpuPkg::EXT_HI:cpuPkg::EXT_LO] == cpuPkg::EXT_ARITH);
			end
			cpuPkg::LSHI: aluOp = cpuPkg::ALU_SHIFT; // imm[4:0], always logical
			default: legal = 1'b0; // opcodes 11..15
		endcase
	end

	// strobes qualified by valid, illegal kills write and flags
	assign illegal   = instrValid & ~legal;
	assign writeEn   = instrValid & legal & ~isCmp;
	assign setsFlags = instrValid & legal & flagOp;

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`default_nettype none
`timescale 1ns/1ps

// two async read ports, one sync write port
// dst read address doubles as the write address
module registerFile #(
	parameter int DATA_BITS = 16
) (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             writeEn,   // from decoder
	input  logic [DATA_BITS-1:0]             writeData, // execute unit result
	input  logic [cpuPkg::REG_ADDR_BITS-1:0] srcAddr,
	input  logic [cpuPkg::REG_ADDR_BITS-1:0] dstAddr,   // read and write addr
	output logic [DATA_BITS-1:0]             readData1, // src operand
	output logic [DATA_BITS-1:0]             readData2  // dst operand
);

	logic [DATA_BITS-1:0] regs [cpuPkg::REG_COUNT];

	// every register cleared on reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[dstAddr] <= writeData; // write back at the issuing edge
		end
	end

	// combinational reads, so the next instr sees the new value
	assign readData1 = regs[srcAddr];
	assign readData2 = regs[dstAddr];

endmodule

`default_nettype wire

// File: verilog/shifter.sv
`default_nettype none
`timescale 1ns/1ps

// log barrel shifter, one right shifter used for both directions
// left shifts go through bit reversal
module shifter #(
	parameter int DATA_BITS = 16
) (
	input  logic [DATA_BITS-1:0] value,
	input  logic [4:0]           amount,  // signed, + left, - right
	input  logic                 arith,   // sign fill on right shift
	output logic [DATA_BITS-1:0] shifted
);

	localparam int STAGES = 5; // up to 16 positions

	logic                             goRight;
	logic [STAGES-1:0]                mag;      // shift distance
	logic                             fill;     // bit shifted in
	logic [DATA_BITS-1:0]             valueRev;
	logic [DATA_BITS-1:0]             outRev;
	logic [STAGES:0][DATA_BITS-1:0]   stage;

	assign goRight = amount[4];
	assign mag     = goRight ? -amount : amount; // -16 gives 16 unsigned
	assign fill    = arith & goRight & value[DATA_BITS-1];

	for (genvar b = 0; b < DATA_BITS; b++) begin : gRev
		assign valueRev[b] = value[DATA_BITS-1-b];
		assign outRev[b]   = stage[STAGES][DATA_BITS-1-b];
	end

	assign stage[0] = goRight ? value : valueRev;

	// stage s moves by 2**s when mag[s] is set
	for (genvar s = 0; s < STAGES; s++) begin : gStage
		logic [2*DATA_BITS-1:0] spread;
		assign spread       = {{DATA_BITS{fill}}, stage[s]} >> (1 << s);
		assign stage[s + 1] = mag[s] ? spread[DATA_BITS-1:0] : stage[s];
	end

	assign shifted = goRight ? stage[STAGES] : outRev; // undo reversal for left

endmodule

`default_nettype wire
